// ==== src/enc_pkg.sv ====
// shared register map and bus types for the encoder block, referenced by scoped names
package enc_pkg;

   // ----------------------------------------
   // register map
   // ----------------------------------------

   // group code sits in adr[5:3], channel in adr[2:0]
   localparam logic [2:0] OFF_POS     = 3'd0;   // overflow + 24-bit count
   localparam logic [2:0] OFF_PERIOD  = 3'd1;   // last edge-to-edge time
   localparam logic [2:0] OFF_RUNNING = 3'd2;   // time since last edge

   // channel 0 of any group answers with this id
   localparam logic [31:0] ID_VALUE = 32'h0000_0B1D;

   // mid-scale start so small moves either way stay positive
   localparam logic [23:0] POS_PRELOAD = 24'h80_0000;

   // timers stop here, never roll over
   localparam logic [31:0] PERIOD_MAX = 32'hFFFF_FFFF;

   // ----------------------------------------
   // per-channel results
   // ----------------------------------------

   typedef struct packed {
      logic [24:0] pos;       // msb is sticky overflow
      logic [31:0] period;    // clocks between last two edges
      logic [31:0] running;   // clocks since last edge
   } enc_chan_t;              // 89 bits

   // ----------------------------------------
   // wishbone classic
   // ----------------------------------------

   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [5:0]  adr;       // {group, channel}
      logic [31:0] dat;       // write data
   } wb_req_t;                // 41 bits

   typedef struct packed {
      logic        ack;       // one clock wide
      logic [31:0] dat;       // read data, valid with ack
   } wb_rsp_t;

endpackage

// ==== src/enc_debounce.sv ====
// one encoder line: synchronize the raw pin and pass only levels held deb_cycles clocks
`timescale 1ns/1ps

module enc_debounce #(
   parameter int deb_cycles = 4         // clocks a new level must hold
) (
   input  logic sysclk,
   input  logic arst_n,
   input  logic raw,                    // pin straight from the connector
   output logic filt                    // cleaned level
);

   localparam int cnt_w = (deb_cycles > 1) ? $clog2(deb_cycles) : 1;

   logic             sync_1;            // metastability stage
   logic             sync_2;            // safe to use from here on
   logic [cnt_w-1:0] cnt;               // clocks the new level has held

   // ----------------------------------------
   // two-flop synchronizer
   // ----------------------------------------
   always_ff @(posedge sysclk or negedge arst_n) begin
      if (!arst_n) begin
         sync_1 <= 1'b0;
         sync_2 <= 1'b0;
      end else begin
         sync_1 <= raw;
         sync_2 <= sync_1;
      end
   end

   // ----------------------------------------
   // stability filter
   // ----------------------------------------
   // cnt only runs while sync_2 disagrees with filt, any bounce back restarts it
   always_ff @(posedge sysclk or negedge arst_n) begin
      if (!arst_n) begin
         cnt  <= '0;
         filt <= 1'b0;
      end else if (sync_2 == filt) begin
         cnt <= '0;                          // nothing pending
      end else if (cnt == cnt_w'(deb_cycles - 1)) begin
         cnt  <= '0;
         filt <= sync_2;                     // held long enough, take it
      end else begin
         cnt <= cnt + 1'b1;
      end
   end

   // a new filt level must have been on sync_2 for the whole window before it
   a_filt_settled: assert property (@(posedge sysclk) disable iff (!arst_n)
      !$stable(filt) |-> ($past(sync_2, 1) == filt) && ($past(sync_2, deb_cycles) == filt))
      else $error("enc_debounce: filt changed before the line settled");

endmodule

// ==== src/enc_quad_counter.sv ====
// quadrature decoder with a preloadable 24-bit position count, sticky overflow and direction
`timescale 1ns/1ps

module enc_quad_counter (
   input  logic        sysclk,
   input  logic        arst_n,
   input  logic        a,                 // filtered a line
   input  logic        b,                 // filtered b line
   input  logic        preload_en,        // one clock, from the bus slave
   input  logic [23:0] preload_val,
   output logic [24:0] pos,               // {overflow, count}
   output logic        dir                // 1 = last step was forward
);

   logic [1:0]  ab;                       // current state
   logic [1:0]  ab_q;                     // state one clock ago
   logic        step_up;
   logic        step_dn;
   logic [23:0] cnt;
   logic        ovf;                      // sticky until next preload

   assign ab = {a, b};

   // ----------------------------------------
   // gray-code step decode
   // ----------------------------------------
   // forward (a leads b): 00 -> 10 -> 11 -> 01 -> 00
   always_comb begin
      step_up = 1'b0;
      step_dn = 1'b0;
      case ({ab_q, ab})
         4'b00_10, 4'b10_11, 4'b11_01, 4'b01_00: step_up = 1'b1;
         4'b00_01, 4'b01_11, 4'b11_10, 4'b10_00: step_dn = 1'b1;
         default: begin
            step_up = 1'b0;                // idle, or both lines moved at once
            step_dn = 1'b0;
         end
      endcase
   end

   // ----------------------------------------
   // position counter
   // ----------------------------------------
   always_ff @(posedge sysclk or negedge arst_n) begin
      if (!arst_n) begin
         ab_q <= 2'b00;                     // matches filter reset level
         cnt  <= enc_pkg::POS_PRELOAD;
         ovf  <= 1'b0;
         dir  <= 1'b0;
      end else begin
         ab_q <= ab;
         if (preload_en) begin
            cnt <= preload_val;             // host write wins over a step
            ovf <= 1'b0;
         end else if (step_up) begin
            cnt <= cnt + 1'b1;
            if (&cnt)
               ovf <= 1'b1;                 // ffffff -> 0
         end else if (step_dn) begin
            cnt <= cnt - 1'b1;
            if (cnt == '0)
               ovf <= 1'b1;                 // 0 -> ffffff
         end
         if (step_up)
            dir <= 1'b1;
         else if (step_dn)
            dir <= 1'b0;
      end
   end

   assign pos = {ovf, cnt};

   // a bus preload lands exactly, whatever the encoder did that clock
   a_preload_wins: assert property (@(posedge sysclk) disable iff (!arst_n)
      preload_en |=> (pos == {1'b0, $past(preload_val)}))
      else $error("enc_quad_counter: preload value lost");

endmodule

// ==== src/enc_period_meter.sv ====
// per-channel timing: clocks between quadrature edges and clocks since the last one
`timescale 1ns/1ps

module enc_period_meter (
   input  logic        sysclk,
   input  logic        arst_n,
   input  logic        a,                 // filtered a line
   input  logic        b,                 // filtered b line
   output logic [31:0] period,            // last edge-to-edge time
   output logic [31:0] running            // time since last edge
);

   logic        a_q;
   logic        b_q;
   logic        line_edge;                // either line moved
   logic        armed;                    // set once the first edge is seen
   logic [31:0] run_cnt;
   logic [31:0] run_inc;                  // saturating next count
   logic [31:0] per_q;

   // ----------------------------------------
   // edge detect
   // ----------------------------------------
   assign line_edge = (a ^ a_q) | (b ^ b_q);

   // stop at the top, a stalled axis must not look fast
   assign run_inc = (run_cnt == enc_pkg::PERIOD_MAX) ? run_cnt : run_cnt + 32'd1;

   // ----------------------------------------
   // timers
   // ----------------------------------------
   always_ff @(posedge sysclk or negedge arst_n) begin
      if (!arst_n) begin
         a_q     <= 1'b0;
         b_q     <= 1'b0;
         armed   <= 1'b0;
         run_cnt <= '0;
         per_q   <= '0;
      end else begin
         a_q <= a;
         b_q <= b;
         if (line_edge) begin
            per_q   <= run_inc;              // count + 1 covers the edge clock
            run_cnt <= '0;
            armed   <= 1'b1;
         end else if (armed) begin
            run_cnt <= run_inc;
         end
         // until the first edge running stays at zero
      end
   end

   assign period  = per_q;
   assign running = run_cnt;

   // once saturated, only an edge may move the counter
   a_run_no_wrap: assert property (@(posedge sysclk) disable iff (!arst_n)
      ($past(run_cnt) == enc_pkg::PERIOD_MAX) |-> (run_cnt == enc_pkg::PERIOD_MAX)
                                                || (run_cnt == '0))
      else $error("enc_period_meter: running counter wrapped");

endmodule

// ==== src/enc_wb_regs.sv ====
// wishbone classic slave: reads channel results by {group, channel}, writes preload positions
`timescale 1ns/1ps

module enc_wb_regs #(
   parameter int num_channels = 4         // 1 to 7, channel 0 is the id slot
) (
   input  logic                                sysclk,
   input  logic                                arst_n,
   input  enc_pkg::wb_req_t                    req,
   output enc_pkg::wb_rsp_t                    rsp,
   input  enc_pkg::enc_chan_t [num_channels:1] chan,
   output logic [num_channels:1]               preload_en,  // one-hot
   output logic [23:0]                         preload_val  // shared by all counters
);

   logic [2:0]         grp;              // adr[5:3]
   logic [2:0]         ch;               // adr[2:0]
   logic               req_valid;
   logic               ack_q;
   logic               hold_q;           // acked, waiting for cyc/stb to drop
   logic               ack_set;          // ack goes high next clock
   logic               wr_pos;
   logic               ch_hit;           // channel number is populated
   enc_pkg::enc_chan_t sel;
   logic [31:0]        rd_word;
   logic [31:0]        dat_q;

   // 3-bit channel field limits the count
   if (num_channels < 1 || num_channels > 7) begin : g_bad_count
      $error("enc_wb_regs: num_channels must be 1 to 7");
   end

   assign grp       = req.adr[5:3];
   assign ch        = req.adr[2:0];
   assign req_valid = req.cyc & req.stb;
   assign ack_set   = req_valid & ~ack_q & ~hold_q;
   assign wr_pos    = ack_set & req.we & (grp == enc_pkg::OFF_POS);

   // ----------------------------------------
   // read select
   // ----------------------------------------
   always_comb begin
      sel    = '0;
      ch_hit = 1'b0;
      for (int i = 1; i <= num_channels; i++) begin
         if (ch == 3'(i)) begin
            sel    = chan[i];
            ch_hit = 1'b1;
         end
      end
   end

   always_comb begin
      if (ch == 3'd0) begin
         rd_word = enc_pkg::ID_VALUE;           // id in every group
      end else if (!ch_hit) begin
         rd_word = '0;                          // unpopulated channel
      end else begin
         case (grp)
            enc_pkg::OFF_POS:     rd_word = {7'd0, sel.pos};
            enc_pkg::OFF_PERIOD:  rd_word = sel.period;
            enc_pkg::OFF_RUNNING: rd_word = sel.running;
            default:              rd_word = '0; // groups 3..7 unused
         endcase
      end
   end

   // ----------------------------------------
   // handshake and preload strobe
   // ----------------------------------------
   always_ff @(posedge sysclk or negedge arst_n) begin
      if (!arst_n) begin
         ack_q      <= 1'b0;
         hold_q     <= 1'b0;
         preload_en <= '0;
      end else begin
         ack_q  <= ack_set;
         hold_q <= (hold_q | ack_q) & req_valid;  // clears on the idle clock
         for (int i = 1; i <= num_channels; i++)
            preload_en[i] <= wr_pos & (ch == 3'(i));
      end
   end

   // data sampled at the edge that raises ack
   always_ff @(posedge sysclk) begin
      if (ack_set)
         dat_q <= rd_word;
      if (wr_pos)
         preload_val <= req.dat[23:0];
   end

   assign rsp = '{ack: ack_q, dat: dat_q};

   a_ack_single: assert property (@(posedge sysclk) disable iff (!arst_n)
      ack_q |=> !ack_q)
      else $error("enc_wb_regs: ack held for two clocks");

endmodule

// ==== src/enc_ctrl.sv ====
// encoder interface top: per-channel filters, counters and timers behind one wishbone slave
`timescale 1ns/1ps

module enc_ctrl #(
   parameter int num_channels = 4,        // 1 to 7
   parameter int deb_cycles   = 4         // filter length in clocks
) (
   input  logic                  sysclk,
   input  logic                  arst_n,
   input  logic [num_channels:1] enc_a,   // raw quadrature inputs
   input  logic [num_channels:1] enc_b,
   input  enc_pkg::wb_req_t      req,
   output enc_pkg::wb_rsp_t      rsp
);

   // ----------------------------------------
   // local nets
   // ----------------------------------------
   wire [num_channels:1]               a_filt;        // debounced lines
   wire [num_channels:1]               b_filt;
   wire [num_channels:1]               preload_en;    // one-hot load strobe
   wire [23:0]                         preload_val;
   wire enc_pkg::enc_chan_t [num_channels:1] chan;    // results per channel

   // ----------------------------------------
   // per-channel datapath
   // ----------------------------------------
   for (genvar i = 1; i <= num_channels; i++) begin : g_chan
      enc_debounce #(.deb_cycles(deb_cycles)) u_deb_a (
         .sysclk (sysclk),
         .arst_n (arst_n),
         .raw    (enc_a[i]),
         .filt   (a_filt[i])
      );

      enc_debounce #(.deb_cycles(deb_cycles)) u_deb_b (
         .sysclk (sysclk),
         .arst_n (arst_n),
         .raw    (enc_b[i]),
         .filt   (b_filt[i])
      );

      // direction not mapped to a register yet
      enc_quad_counter u_quad (
         .sysclk      (sysclk),
         .arst_n      (arst_n),
         .a           (a_filt[i]),
         .b           (b_filt[i]),
         .preload_en  (preload_en[i]),
         .preload_val (preload_val),
         .pos         (chan[i].pos),
         .dir         ()
      );

      enc_period_meter u_perd (
         .sysclk  (sysclk),
         .arst_n  (arst_n),
         .a       (a_filt[i]),
         .b       (b_filt[i]),
         .period  (chan[i].period),
         .running (chan[i].running)
      );
   end

   // ----------------------------------------
   // host register access
   // ----------------------------------------
   enc_wb_regs #(.num_channels(num_channels)) u_regs (
      .sysclk      (sysclk),
      .arst_n      (arst_n),
      .req         (req),
      .rsp         (rsp),
      .chan        (chan),
      .preload_en  (preload_en),
      .preload_val (preload_val)
   );

endmodule

// ==== verification/enc_checker.sv ====
// bus monitor: checks each access at the DUT ports against the value handed over by the testbench
`timescale 1ns/1ps

module enc_checker (
   input  logic             sysclk,
   input  logic             arst_n,
   input  enc_pkg::wb_req_t req,          // as seen by the DUT
   input  enc_pkg::wb_rsp_t rsp,
   input  logic             arm,          // one clock, alongside the request
   input  logic [31:0]      exp,
   input  logic [31:0]      tol,
   input  int               id,
   output int               pass_cnt,
   output int               fail_cnt
);

   logic        pending;                  // access armed, no ack yet
   logic        is_read;
   logic [5:0]  adr_q;
   logic [31:0] exp_q;
   logic [31:0] tol_q;
   int          id_q;
   int          waited;                   // clocks without ack

   // falling edge, bus outputs settled by then
   always @(negedge sysclk or negedge arst_n) begin
      if (!arst_n) begin
         pending  = 1'b0;
         pass_cnt = 0;
         fail_cnt = 0;
      end else begin
         if (arm && !pending) begin
            pending = 1'b1;
            is_read = !req.we;
            adr_q   = req.adr;
            exp_q   = exp;
            tol_q   = tol;
            id_q    = id;
            waited  = 0;
         end
         if (pending && rsp.ack) begin
            pending = 1'b0;
            if (!is_read) begin
               pass_cnt++;
               $display("test %0d ok: write to adr 0x%02h acknowledged", id_q, adr_q);
            end else if (rsp.dat >= exp_q && rsp.dat - exp_q <= tol_q) begin
               pass_cnt++;
               $display("test %0d ok: adr 0x%02h read 0x%08h", id_q, adr_q, rsp.dat);
            end else begin
               fail_cnt++;
               $display("error at %0t ns: rsp.dat = 0x%08h, expected 0x%08h..0x%08h (test %0d)",
                        $time, rsp.dat, exp_q, exp_q + tol_q, id_q);
            end
         end else if (pending) begin
            waited++;
            if (waited >= 4) begin           // slave owes ack on the next clock
               pending = 1'b0;
               fail_cnt++;
               $display("test %0d failed: ack never came within 4 cycles for adr 0x%02h",
                        id_q, adr_q);
            end
         end else if (rsp.ack) begin
            fail_cnt++;
            $display("ack seen at %0t ns with no access pending", $time);
         end
      end
   end

endmodule

// ==== verification/enc_tb.sv ====
// testbench top: runs a table of encoder moves and bus accesses against the encoder block
`timescale 1ns/1ps

module enc_tb;

   localparam int num_channels = 4;
   localparam int deb_cycles   = 4;
   localparam int latency      = 2 + deb_cycles + 1;  // raw pin to read data
   localparam logic [2:0] G_POS = enc_pkg::OFF_POS;
   localparam logic [2:0] G_PER = enc_pkg::OFF_PERIOD;
   localparam logic [2:0] G_RUN = enc_pkg::OFF_RUNNING;
   localparam logic [1:0] gray_seq [4] = '{2'b00, 2'b10, 2'b11, 2'b01};  // {a,b}, a leads

   typedef enum logic [1:0] {OP_MOVE, OP_GLITCH, OP_WRITE, OP_READ} op_t;

   typedef struct packed {
      op_t         op;
      logic [5:0]  adr;     // {group, channel}
      logic [31:0] val;     // signed steps, pulse width or write data
      logic [15:0] hold;    // clocks per step, or idle clocks after
      logic [31:0] exp;     // lowest acceptable read value
      logic [31:0] tol;     // allowed excess over exp
   } step_t;

   logic                       sysclk = 1'b0;
   logic                       arst_n;
   logic [num_channels:1]      enc_a;
   logic [num_channels:1]      enc_b;
   enc_pkg::wb_req_t           req;
   enc_pkg::wb_rsp_t           rsp;
   logic                       chk_arm;           // hands one access to the checker
   logic [31:0]                chk_exp;
   logic [31:0]                chk_tol;
   int                         chk_id;
   int                         pass_cnt;
   int                         fail_cnt;
   logic [num_channels:1][1:0] phase;             // gray position per channel
   step_t                      steps_q[$];
   logic [31:0]                rng    = 32'd5082;
   int                         limit  = 2;        // reset clocks, table adds the rest
   int                         cycles = 0;
   int                         n_tests = 0;       // bus accesses the checker must pass

   enc_ctrl #(.num_channels(num_channels), .deb_cycles(deb_cycles)) uut (
      .sysclk(sysclk), .arst_n(arst_n), .enc_a(enc_a), .enc_b(enc_b), .req(req), .rsp(rsp)
   );

   enc_checker u_check (
      .sysclk(sysclk), .arst_n(arst_n), .req(req), .rsp(rsp), .arm(chk_arm),
      .exp(chk_exp), .tol(chk_tol), .id(chk_id), .pass_cnt(pass_cnt), .fail_cnt(fail_cnt)
   );

   always #50 sysclk = ~sysclk;                   // 100 ns period

   always @(posedge sysclk) begin
      cycles <= cycles + 1;
      if (cycles > limit) begin
         $display("timeout: run still going after %0d clock cycles", cycles);
         $display("TESTS FAILED");
         $finish;
      end
   end

   // ----------------------------------------
   // helpers
   // ----------------------------------------
   task automatic tick(input int n);
      repeat (n) @(posedge sysclk);
      #1;                                         // drive point, just after the edge
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   // count wraps at 24 bits, a wrap either way sets bit 24
   function automatic logic [31:0] pos_word(input logic [23:0] start, input int steps);
      longint t;
      t = longint'(start) + steps;
      return {7'd0, (t < 0 || t > 16777215), t[23:0]};
   endfunction

   task automatic add(input op_t op, input logic [5:0] adr, input logic [31:0] val,
                      input int hold, input logic [31:0] exp, input logic [31:0] tol);
      int n;
      steps_q.push_back('{op, adr, val, 16'(hold), exp, tol});
      n = $signed(val);
      case (op)
         OP_MOVE:   limit += ((n < 0) ? -n : n) * hold;
         OP_GLITCH: limit += n + hold;
         default: begin
            limit   += hold;
            n_tests += 1;
         end
      endcase
      limit += 20;                                // margin per entry
   endtask

   task automatic do_move(input logic [2:0] ch, input int steps, input int hold);
      repeat ((steps < 0) ? -steps : steps) begin
         phase[ch] = (steps < 0) ? phase[ch] - 2'd1 : phase[ch] + 2'd1;
         {enc_a[ch], enc_b[ch]} = gray_seq[phase[ch]];
         tick(hold);
      end
   endtask

   task automatic do_glitch(input logic [2:0] ch, input int width, input int hold);
      enc_a[ch] = ~enc_a[ch];
      tick(width);
      enc_a[ch] = ~enc_a[ch];                     // back before the filter settles
      tick(hold);
   endtask

   task automatic bus_cycle(input step_t s, input int id);
      int n = 0;
      req     = '{cyc: 1'b1, stb: 1'b1, we: s.op == OP_WRITE, adr: s.adr, dat: s.val};
      chk_arm = 1'b1;
      chk_exp = s.exp;
      chk_tol = s.tol;
      chk_id  = id;
      tick(1);
      chk_arm = 1'b0;
      while (!rsp.ack && n < 6) begin             // checker reports a missing ack
         tick(1);
         n++;
      end
      req = '0;
      tick(1 + s.hold);                           // idle clock before the next access
   endtask

   // ----------------------------------------
   // stimulus table
   // ----------------------------------------
   task automatic build_table();
      logic [23:0] r;
      logic [23:0] mid;
      mid = enc_pkg::POS_PRELOAD;
      for (int g = 0; g < 3; g++)
         add(OP_READ, {3'(g), 3'd0}, 0, 0, enc_pkg::ID_VALUE, 0);
      for (int c = 1; c <= num_channels; c++) begin   // idle after reset
         add(OP_READ, {G_POS, 3'(c)}, 0, 0, pos_word(mid, 0), 0);
         add(OP_READ, {G_PER, 3'(c)}, 0, 0, 0, 0);
         add(OP_READ, {G_RUN, 3'(c)}, 0, 0, 0, 0);
      end
      add(OP_MOVE, {G_POS, 3'd1}, 5, 12, 0, 0);       // forward on 1
      add(OP_READ, {G_POS, 3'd1}, 0, 0, pos_word(mid, 5), 0);
      add(OP_READ, {G_POS, 3'd2}, 0, 0, pos_word(mid, 0), 0);
      add(OP_MOVE, {G_POS, 3'd2}, -3, 12, 0, 0);      // reverse on 2
      add(OP_READ, {G_POS, 3'd2}, 0, 0, pos_word(mid, -3), 0);
      add(OP_READ, {G_POS, 3'd1}, 0, 0, pos_word(mid, 5), 0);
      rng = xorshift32(rng);
      r   = rng[23:0];
      add(OP_WRITE, {G_POS, 3'd3}, {8'd0, r}, 0, 0, 0);
      add(OP_READ, {G_POS, 3'd3}, 0, 0, pos_word(r, 0), 0);
      add(OP_MOVE, {G_POS, 3'd3}, 3, 12, 0, 0);
      add(OP_READ, {G_POS, 3'd3}, 0, 0, pos_word(r, 3), 0);
      add(OP_GLITCH, {G_POS, 3'd4}, 2, 12, 0, 0);     // shorter than the filter
      add(OP_READ, {G_POS, 3'd4}, 0, 0, pos_word(mid, 0), 0);
      add(OP_READ, {G_PER, 3'd4}, 0, 0, 0, 0);
      add(OP_MOVE, {G_POS, 3'd1}, 4, 20, 0, 0);       // steady steps of 20 clocks
      add(OP_READ, {G_RUN, 3'd1}, 0, 0, 20 - latency, 2);
      add(OP_READ, {G_PER, 3'd1}, 0, 0, 20, 0);
      add(OP_READ, {G_POS, 3'd1}, 0, 0, pos_word(mid, 9), 0);
      add(OP_WRITE, {G_PER, 3'd1}, 32'h123, 0, 0, 0); // not a preload
      add(OP_READ, {G_POS, 3'd1}, 0, 0, pos_word(mid, 9), 0);
      add(OP_WRITE, {G_POS, 3'd2}, 32'hFF_FFFF, 0, 0, 0);
      add(OP_MOVE, {G_POS, 3'd2}, 1, 12, 0, 0);
      add(OP_READ, {G_POS, 3'd2}, 0, 0, pos_word(24'hFF_FFFF, 1), 0);
      rng = xorshift32(rng);
      r   = rng[23:0];
      add(OP_WRITE, {G_POS, 3'd2}, {8'd0, r}, 0, 0, 0);   // clears overflow
      add(OP_READ, {G_POS, 3'd2}, 0, 0, pos_word(r, 0), 0);
      add(OP_WRITE, {G_POS, 3'd4}, 0, 0, 0, 0);
      add(OP_MOVE, {G_POS, 3'd4}, -1, 12, 0, 0);      // wrap downward
      add(OP_READ, {G_POS, 3'd4}, 0, 0, pos_word(24'd0, -1), 0);
      add(OP_READ, {3'd3, 3'd1}, 0, 0, 0, 0);         // unused group
      add(OP_READ, {G_PER, 3'd5}, 0, 0, 0, 0);        // channel not built
   endtask

   initial begin
      step_t s;
      arst_n  = 1'b0;
      enc_a   = '0;
      enc_b   = '0;
      req     = '0;
      chk_arm = 1'b0;
      chk_exp = '0;
      chk_tol = '0;
      chk_id  = 0;
      phase   = '0;
      build_table();
      repeat (2) @(posedge sysclk);
      #1 arst_n = 1'b1;
      tick(1);
      foreach (steps_q[i]) begin
         s = steps_q[i];
         case (s.op)
            OP_MOVE:   do_move(s.adr[2:0], $signed(s.val), s.hold);
            OP_GLITCH: do_glitch(s.adr[2:0], s.val, s.hold);
            default:   bus_cycle(s, i);
         endcase
      end
      tick(2);
      $display("summary: %0d of %0d checks passed, %0d failed", pass_cnt, n_tests, fail_cnt);
      if (fail_cnt == 0 && pass_cnt == n_tests)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

// ==== filelist.f ====
src/enc_pkg.sv
src/enc_debounce.sv
src/enc_quad_counter.sv
src/enc_period_meter.sv
src/enc_wb_regs.sv
src/enc_ctrl.sv
verification/enc_checker.sv
verification/enc_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the encoder testbench with verilator, run it, then search the log for the failure line

verilator --binary --assert -Wno-fatal --top-module enc_tb -Mdir obj_dir -f filelist.f \
   > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Venc_tb > sim.log 2>&1 || echo "simulation exited with an error" >> sim.log
cat sim.log

grep -q "TESTS FAILED" sim.log && exit 1 || grep -q "TESTS PASSED" sim.log
